// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --timing
TOP       := rv32i_exec_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/rv32i_exec_tb.sv
// table driven testbench for the apb controlled rv32i execution subsystem
// expected values come from a small isa model run ahead over the stimulus table

module rv32i_exec_tb
import rv32i_types::*;
();

    localparam logic [31:0] RESET_PC = 32'h0000_1000;
    localparam int          MAX_ROWS = 80;
    localparam int          TIMEOUT  = 20;

    logic        clk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    // isa model state that runs ahead while the table is built
    logic [31:0] mregs [32];
    logic [31:0] mpc;

    // register image expected on the dut while the table is applied
    logic [31:0] exp_regs [32];
    logic [31:0] exp_result;

    logic [31:0] tbl_instr [MAX_ROWS];
    logic [31:0] tbl_pc    [MAX_ROWS];
    logic [4:0]  tbl_rd    [MAX_ROWS];
    logic [31:0] tbl_val   [MAX_ROWS];
    logic        tbl_ill   [MAX_ROWS];
    int          n_rows;
    integer      seed;

    rv32i_exec_top #(
        .RESET_PC(RESET_PC)
    ) u_rv32i_exec_top (
        .clk    (clk),
        .rst    (rst),
        .psel   (psel),
        .penable(penable),
        .pwrite (pwrite),
        .paddr  (paddr),
        .pwdata (pwdata),
        .prdata (prdata),
        .pready (pready),
        .pslverr(pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp);
            abort_run("value check failed");
        end
    endtask

    // called just after a falling edge and returns once pready is high before the rising edge
    task automatic wait_ready(output int waits);
        waits = 0;
        #5;
        while (!pready) begin
            if (waits >= TIMEOUT) begin
                abort_run("timeout: pready stayed low for too many cycles");
            end
            @(negedge clk);
            #5;
            waits++;
        end
    endtask

    task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        int waits;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        wait_ready(waits);
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic reg_read(input logic [11:0] addr, output logic [31:0] data);
        logic err;
        apb_xfer(1'b0, addr, 32'd0, data, err);
        check_val("pslverr", {31'd0, err}, 32'd0);
    endtask

    task automatic reg_write(input logic [11:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        logic        err;
        apb_xfer(1'b1, addr, data, unused, err);
        check_val("pslverr", {31'd0, err}, 32'd0);
    endtask

    // two instruction writes whose access phases follow each other directly
    task automatic write_pair(input logic [31:0] first, input logic [31:0] second,
                              output int stall);
        int waits;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = ADDR_INSTR;
        pwdata  = first;
        @(negedge clk);
        penable = 1'b1;
        wait_ready(waits);
        check_val("first write waits", 32'(waits), 32'd0);
        @(negedge clk);
        pwdata = second;
        wait_ready(stall);
        check_val("pslverr", {31'd0, pslverr}, 32'd0);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    function automatic logic [11:0] reg_addr(input logic [4:0] idx);
        return ADDR_REG_BASE | {5'd0, idx, 2'b00};
    endfunction

    task automatic check_all_regs();
        logic [31:0] d;
        for (int i = 0; i < 32; i++) begin
            reg_read(reg_addr(5'(i)), d);
            check_val($sformatf("x%0d", i), d, exp_regs[i]);
        end
    endtask

    function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'h13};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] enc_u(input logic [6:0] op, input logic [4:0] rd,
                                          input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    // rv32i base integer rules for lui, auipc, op-imm and op
    task automatic model_step(input logic [31:0] ins, output logic [4:0] rd,
                              output logic [31:0] val, output logic ill);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] uimm;
        logic [4:0]  sh;
        logic        is_op;
        rd    = ins[11:7];
        a     = mregs[ins[19:15]];
        imm   = {{20{ins[31]}}, ins[31:20]};
        uimm  = {ins[31:12], 12'h000};
        is_op = (ins[6:0] == 7'h33);
        b     = is_op ? mregs[ins[24:20]] : imm;
        sh    = b[4:0];
        ill   = 1'b0;
        val   = 32'd0;
        case (ins[6:0])
            7'h37: val = uimm;
            7'h17: val = mpc + uimm;
            7'h13, 7'h33: begin
                case (ins[14:12])
                    3'd0: begin
                        if (is_op && ins[30]) begin
                            val = a - b;
                        end else begin
                            val = a + b;
                        end
                    end
                    3'd1: val = a << sh;
                    3'd2: val = {31'd0, $signed(a) < $signed(b)};
                    3'd3: val = {31'd0, a < b};
                    3'd4: val = a ^ b;
                    3'd5: begin
                        if (ins[30]) begin
                            val = $signed(a) >>> sh;
                        end else begin
                            val = a >> sh;
                        end
                    end
                    3'd6: val = a | b;
                    default: val = a & b;
                endcase
            end
            default: ill = 1'b1;
        endcase
        if (!ill) begin
            mpc = mpc + 32'd4;
            if (rd != 5'd0) begin
                mregs[rd] = val;
            end
        end
    endtask

    task automatic add_row(input logic [31:0] ins);
        logic [4:0]  rd;
        logic [31:0] val;
        logic        ill;
        tbl_pc[n_rows] = mpc;
        model_step(ins, rd, val, ill);
        tbl_instr[n_rows] = ins;
        tbl_rd[n_rows]    = rd;
        tbl_val[n_rows]   = val;
        tbl_ill[n_rows]   = ill;
        n_rows++;
    endtask

    task automatic build_table();
        logic [31:0] r;
        logic [11:0] imm;
        // seed x1..x12 with addi and lui plus addi
        for (int k = 1; k <= 8; k++) begin
            r = $random(seed);
            add_row(enc_i(3'd0, 5'(k), 5'd0, r[11:0]));
        end
        for (int k = 9; k <= 12; k++) begin
            r = $random(seed);
            // rs1 bits of each lui name an already seeded register
            add_row(enc_u(7'h37, 5'(k), {r[31:20], 5'(k - 8), r[14:12]}));
            add_row(enc_i(3'd0, 5'(k), 5'(k), r[11:0]));
        end
        for (int round = 0; round < 2; round++) begin
            for (int f3 = 0; f3 < 8; f3++) begin
                r   = $random(seed);
                imm = r[11:0];
                if (f3 == 1 || f3 == 5) begin
                    imm = {7'd0, r[24:20]};
                end
                add_row(enc_i(3'(f3), r[29:25], {1'b0, r[15:12]}, imm));
            end
            r = $random(seed);
            add_row(enc_i(3'd5, r[29:25], {1'b0, r[15:12]}, {7'h20, r[24:20]}));
            for (int f3 = 0; f3 < 8; f3++) begin
                r = $random(seed);
                add_row(enc_r(7'd0, {1'b0, r[19:16]}, {1'b0, r[15:12]}, 3'(f3), r[29:25]));
            end
            r = $random(seed);
            add_row(enc_r(7'h20, {1'b0, r[19:16]}, {1'b0, r[15:12]}, 3'd0, r[29:25]));
            r = $random(seed);
            add_row(enc_r(7'h20, {1'b0, r[19:16]}, {1'b0, r[15:12]}, 3'd5, r[29:25]));
            r = $random(seed);
            add_row(enc_u(7'h17, r[29:25], r[31:12]));
            add_row(enc_r(7'd0, 5'd2, 5'd1, 3'd0, 5'd0));
        end
        // sw x2, 0(x1) and beq x1, x2, +8
        add_row(32'h0020_a023);
        add_row(32'h0020_8463);
    endtask

    initial begin
        logic [31:0] d;
        logic [31:0] pc_now;
        logic        err;
        logic [4:0]  rd_a;
        logic [4:0]  rd_b;
        logic [31:0] val_a;
        logic [31:0] val_b;
        logic        ill;
        int          stall;

        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = 12'd0;
        pwdata  = 32'd0;
        seed    = 32'hba3be7f8;
        n_rows  = 0;
        mpc     = RESET_PC;
        exp_result = 32'd0;
        for (int i = 0; i < 32; i++) begin
            mregs[i]    = 32'd0;
            exp_regs[i] = 32'd0;
        end
        build_table();

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // state right after reset
        reg_read(ADDR_PC, d);
        check_val("pc", d, RESET_PC);
        reg_read(ADDR_STATUS, d);
        check_val("status", d, 32'd0);
        reg_read(ADDR_RESULT, d);
        check_val("result", d, 32'd0);
        check_all_regs();

        for (int i = 0; i < n_rows; i++) begin
            reg_read(ADDR_PC, pc_now);
            check_val("pc", pc_now, tbl_pc[i]);
            reg_write(ADDR_INSTR, tbl_instr[i]);
            if (tbl_ill[i]) begin
                reg_read(ADDR_STATUS, d);
                check_val("status", d, 32'd1);
                reg_read(ADDR_PC, d);
                check_val("pc", d, pc_now);
                reg_read(ADDR_RESULT, d);
                check_val("result", d, exp_result);
                check_all_regs();
                reg_write(ADDR_STATUS, 32'd1);
                reg_read(ADDR_STATUS, d);
                check_val("status", d, 32'd0);
            end else begin
                if (tbl_rd[i] != 5'd0) begin
                    exp_regs[tbl_rd[i]] = tbl_val[i];
                end
                exp_result = tbl_val[i];
                reg_read(reg_addr(tbl_rd[i]), d);
                check_val($sformatf("x%0d", tbl_rd[i]), d, exp_regs[tbl_rd[i]]);
                reg_read(ADDR_RESULT, d);
                check_val("result", d, exp_result);
                if (tbl_instr[i][6:0] == 7'h17) begin
                    check_val("auipc result", d, pc_now + {tbl_instr[i][31:12], 12'h000});
                end
                reg_read(ADDR_PC, d);
                check_val("pc", d, pc_now + 32'd4);
            end
        end

        // bad accesses flag pslverr and leave state alone
        apb_xfer(1'b1, ADDR_PC, 32'hdead_beef, d, err);
        check_val("pslverr", {31'd0, err}, 32'd1);
        apb_xfer(1'b1, ADDR_RESULT, 32'hdead_beef, d, err);
        check_val("pslverr", {31'd0, err}, 32'd1);
        apb_xfer(1'b1, reg_addr(5'd5), 32'hdead_beef, d, err);
        check_val("pslverr", {31'd0, err}, 32'd1);
        apb_xfer(1'b0, 12'h010, 32'd0, d, err);
        check_val("pslverr", {31'd0, err}, 32'd1);
        apb_xfer(1'b0, 12'h044, 32'd0, d, err);
        check_val("pslverr", {31'd0, err}, 32'd1);
        reg_read(ADDR_PC, d);
        check_val("pc", d, mpc);
        reg_read(ADDR_RESULT, d);
        check_val("result", d, exp_result);
        check_all_regs();

        // dependent pair where the second access lands in the issue cycle
        d = $random(seed);
        model_step(enc_i(3'd0, 5'd20, 5'd0, d[11:0]), rd_a, val_a, ill);
        model_step(enc_r(7'd0, 5'd20, 5'd20, 3'd0, 5'd21), rd_b, val_b, ill);
        write_pair(enc_i(3'd0, 5'd20, 5'd0, d[11:0]), enc_r(7'd0, 5'd20, 5'd20, 3'd0, 5'd21),
                   stall);
        check_val("pready stall cycles", 32'(stall), 32'd1);
        exp_regs[rd_a] = val_a;
        exp_regs[rd_b] = val_b;
        reg_read(reg_addr(5'd21), d);
        check_val("x21", d, val_b);
        reg_read(ADDR_RESULT, d);
        check_val("result", d, val_b);
        reg_read(ADDR_PC, d);
        check_val("pc", d, mpc);
        check_all_regs();

        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: files.f
logic/rv32i_types.sv
logic/apb_cmd_regs.sv
logic/id_stage.sv
logic/regfile.sv
logic/ex_stage.sv
logic/rv32i_exec_top.sv
dv/rv32i_exec_tb.sv

// File: logic/apb_cmd_regs.sv
// apb slave front end: takes instruction words from the host and issues them
// one at a time, and serves pc, result, status and register readback

module apb_cmd_regs
import rv32i_types::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [11:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,

    input  logic [31:0] pc,
    input  logic [31:0] last_result,
    input  logic        illegal_seen,
    input  logic [31:0] dbg_val,

    output logic [31:0] instr,
    output logic        issue,
    output logic        err_clear,
    output logic [4:0]  dbg_idx
);

    logic hit_instr;
    logic hit_pc;
    logic hit_result;
    logic hit_status;
    logic hit_reg;
    logic rd_ok;
    logic wr_ok;
    logic access;
    logic wr_fire;

    // address decode
    assign hit_instr  = (paddr == ADDR_INSTR);
    assign hit_pc     = (paddr == ADDR_PC);
    assign hit_result = (paddr == ADDR_RESULT);
    assign hit_status = (paddr == ADDR_STATUS);
    assign hit_reg    = (paddr[11:7] == ADDR_REG_BASE[11:7]) && (paddr[1:0] == 2'b00);

    assign rd_ok = hit_instr | hit_pc | hit_result | hit_status | hit_reg;
    assign wr_ok = hit_instr | hit_status;

    // stall any access phase that overlaps the issue cycle
    assign pready  = ~issue;
    assign access  = psel & penable & pready;
    assign wr_fire = access & pwrite & wr_ok;

    assign pslverr = psel & penable & (pwrite ? ~wr_ok : ~rd_ok);

    assign dbg_idx = paddr[6:2];

    // write 1 to status bit 0 clears the sticky flag
    assign err_clear = wr_fire & hit_status & pwdata[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            instr <= '0;
            issue <= 1'b0;
        end else begin
            issue <= wr_fire & hit_instr;
            if (wr_fire && hit_instr) begin
                instr <= pwdata;
            end
        end
    end

    // read mux, instr is write-only and reads back as zero
    always_comb begin
        prdata = '0;
        if (!pwrite) begin
            if (hit_pc) begin
                prdata = pc;
            end else if (hit_result) begin
                prdata = last_result;
            end else if (hit_status) begin
                prdata = {31'd0, illegal_seen};
            end else if (hit_reg) begin
                prdata = dbg_val;
            end
        end
    end

endmodule

// File: logic/ex_stage.sv
// execute stage: operand select, alu, compare and writeback
// also owns the program counter and the sticky illegal flag

module ex_stage
import rv32i_types::*;
#(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rst,

    input  logic        valid,
    input  logic        illegal,
    input  logic        err_clear,

    input  alu_op_t     alu_op,
    input  cmp_op_t     cmp_op,
    input  alu_m1_sel_t m1_sel,
    input  alu_m2_sel_t m2_sel,
    input  rd_sel_t     rd_sel,
    input  logic [31:0] i_imm,
    input  logic [31:0] u_imm,
    input  logic [4:0]  rd_idx,
    input  logic [31:0] rs1_val,
    input  logic [31:0] rs2_val,

    output logic        rf_we,
    output logic [4:0]  rf_waddr,
    output logic [31:0] rf_wdata,
    output logic [31:0] pc,
    output logic [31:0] last_result,
    output logic        illegal_seen
);

    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [4:0]  shamt;
    logic [31:0] alu_out;
    logic        cmp_out;
    logic [31:0] wb_val;

    assign op_a = (m1_sel == pc_out) ? pc : rs1_val;

    always_comb begin
        unique case (m2_sel)
            i_imm_m: op_b = i_imm;
            u_imm_m: op_b = u_imm;
            default: op_b = rs2_val;
        endcase
    end

    assign shamt = op_b[4:0];

    always_comb begin
        unique case (alu_op)
            alu_op_add: alu_out = op_a + op_b;
            alu_op_sub: alu_out = op_a - op_b;
            alu_op_sll: alu_out = op_a << shamt;
            alu_op_srl: alu_out = op_a >> shamt;
            alu_op_sra: alu_out = 32'($signed(op_a) >>> shamt);
            alu_op_xor: alu_out = op_a ^ op_b;
            alu_op_or:  alu_out = op_a | op_b;
            default:    alu_out = op_a & op_b;
        endcase
    end

    // op_b is already the i-immediate for op-imm and rs2 for op
    assign cmp_out = (cmp_op == cmp_op_ltu) ? (op_a < op_b)
                                            : ($signed(op_a) < $signed(op_b));

    always_comb begin
        unique case (rd_sel)
            cmp_out_rd: wb_val = {31'd0, cmp_out};
            u_imm_rd:   wb_val = u_imm;
            default:    wb_val = alu_out;
        endcase
    end

    assign rf_we    = valid;
    assign rf_waddr = rd_idx;
    assign rf_wdata = wb_val;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc           <= RESET_PC;
            last_result  <= '0;
            illegal_seen <= 1'b0;
        end else begin
            if (valid) begin
                pc          <= pc + 32'd4;
                last_result <= wb_val;
            end
            if (err_clear) begin
                illegal_seen <= 1'b0;
            end
            // a new illegal word wins over a clear in the same cycle
            if (illegal) begin
                illegal_seen <= 1'b1;
            end
        end
    end

endmodule

// File: logic/id_stage.sv
// instruction decode: fields, immediates and execute control for one word
// purely combinational, qualified by the issue pulse

module id_stage
import rv32i_types::*;
(
    input  logic [31:0] instr,
    input  logic        issue,

    output logic [4:0]  rs1_idx,
    output logic [4:0]  rs2_idx,
    output logic [4:0]  rd_idx,
    output logic [31:0] i_imm,
    output logic [31:0] u_imm,

    output alu_op_t     alu_op,
    output cmp_op_t     cmp_op,
    output alu_m1_sel_t m1_sel,
    output alu_m2_sel_t m2_sel,
    output rd_sel_t     rd_sel,

    output logic        valid,
    output logic        illegal
);

    rv32i_opcode_t opcode;
    arith_f3_t     funct3;
    logic          funct7_b5;
    logic          supported;

    assign opcode    = rv32i_opcode_t'(instr[6:0]);
    assign funct3    = arith_f3_t'(instr[14:12]);
    assign funct7_b5 = instr[30];
    assign rd_idx    = instr[11:7];

    assign i_imm = {{21{instr[31]}}, instr[30:20]};
    assign u_imm = {instr[31:12], 12'h000};

    // control table
    always_comb begin
        alu_op    = alu_op_add;
        cmp_op    = cmp_op_lt;
        m1_sel    = rs1_out;
        m2_sel    = rs2_out;
        rd_sel    = alu_out_rd;
        rs1_idx   = '0;
        rs2_idx   = '0;
        supported = 1'b1;
        unique case (opcode)
            op_lui: begin
                // result comes straight from the immediate
                rd_sel = u_imm_rd;
            end
            op_auipc: begin
                m1_sel = pc_out;
                m2_sel = u_imm_m;
            end
            op_imm: begin
                m2_sel  = i_imm_m;
                rs1_idx = instr[19:15];
                unique case (funct3)
                    arith_f3_slt: begin
                        cmp_op = cmp_op_lt;
                        rd_sel = cmp_out_rd;
                    end
                    arith_f3_sltu: begin
                        cmp_op = cmp_op_ltu;
                        rd_sel = cmp_out_rd;
                    end
                    arith_f3_sr: begin
                        alu_op = funct7_b5 ? alu_op_sra : alu_op_srl;
                    end
                    default: begin
                        alu_op = alu_op_t'(funct3);
                    end
                endcase
            end
            op_reg: begin
                rs1_idx = instr[19:15];
                rs2_idx = instr[24:20];
                unique case (funct3)
                    arith_f3_slt: begin
                        cmp_op = cmp_op_lt;
                        rd_sel = cmp_out_rd;
                    end
                    arith_f3_sltu: begin
                        cmp_op = cmp_op_ltu;
                        rd_sel = cmp_out_rd;
                    end
                    arith_f3_sr: begin
                        alu_op = funct7_b5 ? alu_op_sra : alu_op_srl;
                    end
                    arith_f3_add: begin
                        alu_op = funct7_b5 ? alu_op_sub : alu_op_add;
                    end
                    default: begin
                        alu_op = alu_op_t'(funct3);
                    end
                endcase
            end
            // loads, stores, branches and jumps land here
            default: begin
                supported = 1'b0;
            end
        endcase
    end

    assign valid   = issue & supported;
    assign illegal = issue & ~supported;

endmodule

// File: logic/regfile.sv
// 32 x 32-bit architectural register file
// two decode read ports, one host debug port, one write port

module regfile (
    input  logic        clk,
    input  logic        rst,

    input  logic [4:0]  rs1_idx,
    input  logic [4:0]  rs2_idx,
    input  logic [4:0]  dbg_idx,

    input  logic        rf_we,
    input  logic [4:0]  rf_waddr,
    input  logic [31:0] rf_wdata,

    output logic [31:0] rs1_val,
    output logic [31:0] rs2_val,
    output logic [31:0] dbg_val
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_we && (rf_waddr != 5'd0)) begin
            // x0 stays zero
            regs[rf_waddr] <= rf_wdata;
        end
    end

    // asynchronous reads
    assign rs1_val = regs[rs1_idx];
    assign rs2_val = regs[rs2_idx];
    assign dbg_val = regs[dbg_idx];

endmodule

// File: logic/rv32i_exec_top.sv
// top level of the apb controlled rv32i execution subsystem
// connects the apb front end, decoder, register file and execute stage

module rv32i_exec_top
import rv32i_types::*;
#(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [11:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    // apb front end to decode
    logic [31:0] instr;
    logic        issue;
    logic        err_clear;
    logic [4:0]  dbg_idx;
    logic [31:0] dbg_val;

    // decode outputs
    logic [4:0]  rs1_idx;
    logic [4:0]  rs2_idx;
    logic [4:0]  rd_idx;
    logic [31:0] i_imm;
    logic [31:0] u_imm;
    alu_op_t     alu_op;
    cmp_op_t     cmp_op;
    alu_m1_sel_t m1_sel;
    alu_m2_sel_t m2_sel;
    rd_sel_t     rd_sel;
    logic        valid;
    logic        illegal;

    // register file and execute
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic        rf_we;
    logic [4:0]  rf_waddr;
    logic [31:0] rf_wdata;
    logic [31:0] pc;
    logic [31:0] last_result;
    logic        illegal_seen;

    apb_cmd_regs u_apb_cmd_regs (
        .clk         (clk),
        .rst         (rst),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .pc          (pc),
        .last_result (last_result),
        .illegal_seen(illegal_seen),
        .dbg_val     (dbg_val),
        .instr       (instr),
        .issue       (issue),
        .err_clear   (err_clear),
        .dbg_idx     (dbg_idx)
    );

    id_stage u_id_stage (
        .instr  (instr),
        .issue  (issue),
        .rs1_idx(rs1_idx),
        .rs2_idx(rs2_idx),
        .rd_idx (rd_idx),
        .i_imm  (i_imm),
        .u_imm  (u_imm),
        .alu_op (alu_op),
        .cmp_op (cmp_op),
        .m1_sel (m1_sel),
        .m2_sel (m2_sel),
        .rd_sel (rd_sel),
        .valid  (valid),
        .illegal(illegal)
    );

    regfile u_regfile (
        .clk     (clk),
        .rst     (rst),
        .rs1_idx (rs1_idx),
        .rs2_idx (rs2_idx),
        .dbg_idx (dbg_idx),
        .rf_we   (rf_we),
        .rf_waddr(rf_waddr),
        .rf_wdata(rf_wdata),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .dbg_val (dbg_val)
    );

    ex_stage #(
        .RESET_PC(RESET_PC)
    ) u_ex_stage (
        .clk         (clk),
        .rst         (rst),
        .valid       (valid),
        .illegal     (illegal),
        .err_clear   (err_clear),
        .alu_op      (alu_op),
        .cmp_op      (cmp_op),
        .m1_sel      (m1_sel),
        .m2_sel      (m2_sel),
        .rd_sel      (rd_sel),
        .i_imm       (i_imm),
        .u_imm       (u_imm),
        .rd_idx      (rd_idx),
        .rs1_val     (rs1_val),
        .rs2_val     (rs2_val),
        .rf_we       (rf_we),
        .rf_waddr    (rf_waddr),
        .rf_wdata    (rf_wdata),
        .pc          (pc),
        .last_result (last_result),
        .illegal_seen(illegal_seen)
    );

endmodule

// File: logic/rv32i_types.sv
// shared encodings for the rv32i execution subsystem
// opcodes, decode control enums and the apb register map

package rv32i_types;

    // major opcodes handled by the execute stage
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode_t;

    typedef enum logic [2:0] {
        arith_f3_add  = 3'b000,
        arith_f3_sll  = 3'b001,
        arith_f3_slt  = 3'b010,
        arith_f3_sltu = 3'b011,
        arith_f3_xor  = 3'b100,
        arith_f3_sr   = 3'b101,
        arith_f3_or   = 3'b110,
        arith_f3_and  = 3'b111
    } arith_f3_t;

    // shares funct3 codes where possible, sub and sra take the slt/sltu slots
    typedef enum logic [2:0] {
        alu_op_add = 3'b000,
        alu_op_sll = 3'b001,
        alu_op_sub = 3'b010,
        alu_op_sra = 3'b011,
        alu_op_xor = 3'b100,
        alu_op_srl = 3'b101,
        alu_op_or  = 3'b110,
        alu_op_and = 3'b111
    } alu_op_t;

    typedef enum logic {
        cmp_op_lt  = 1'b0,
        cmp_op_ltu = 1'b1
    } cmp_op_t;

    typedef enum logic {
        rs1_out = 1'b0,
        pc_out  = 1'b1
    } alu_m1_sel_t;

    typedef enum logic [1:0] {
        rs2_out = 2'b00,
        i_imm_m = 2'b01,
        u_imm_m = 2'b10
    } alu_m2_sel_t;

    typedef enum logic [1:0] {
        alu_out_rd = 2'b00,
        cmp_out_rd = 2'b01,
        u_imm_rd   = 2'b10
    } rd_sel_t;

    // apb register map, byte addresses
    localparam logic [11:0] ADDR_INSTR    = 12'h000;
    localparam logic [11:0] ADDR_PC       = 12'h004;
    localparam logic [11:0] ADDR_RESULT   = 12'h008;
    localparam logic [11:0] ADDR_STATUS   = 12'h00C;
    localparam logic [11:0] ADDR_REG_BASE = 12'h080;

endpackage
